// ==== dv/axi_patterns.txt ====
# test op master addr len data expected  (op 0 write, 1 read, 2 write with order check)
# addr, data and expected in hex; len is beats minus one; burst words count up by one
1 0 0 00000000 0 11110000 00000000
1 1 0 00000000 0 00000000 11110000
1 0 1 00000004 0 22220000 00000000
1 1 1 00000004 0 00000000 22220000
1 0 2 00000008 0 33330000 00000000
1 1 2 00000008 0 00000000 33330000
1 0 3 0000000c 0 44440000 00000000
1 1 3 0000000c 0 00000000 44440000
2 0 1 10000005 0 5a5a0005 00000000
2 1 1 10000005 0 00000000 5a5a0005
3 0 2 20000007 0 77770007 00000000
3 1 2 10000007 0 00000000 77770007
4 2 3 00000023 0 a0000003 00000000
4 2 1 00000021 0 a0000001 00000000
4 2 0 00000020 0 a0000000 00000000
4 2 2 00000022 0 a0000002 00000000
5 0 0 00000028 7 50000000 00000000
5 1 0 00000028 7 00000000 50000000
5 0 1 00000030 3 51000000 00000000
5 1 1 00000030 3 00000000 51000000
5 0 3 1000000a 5 53000000 00000000
5 1 3 1000000a 5 00000000 53000000
6 1 2 00000028 7 00000000 50000000
6 1 3 1000000a 5 00000000 53000000

// ==== files.f ====
verilog/axi_ic_pkg.sv
verilog/addr_arbiter.sv
verilog/addr_decoder.sv
verilog/wr_data_router.sv
verilog/rd_data_router.sv
verilog/axi_interconnect.sv
dv/axi_slave_model.sv
dv/tb_axi_interconnect.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_axi_interconnect -f files.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_axi_interconnect)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Regression passed"; then
    exit 0
fi
exit 1

// ==== dv/tb_axi_interconnect.sv ====
module tb_axi_interconnect
    import axi_ic_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    logic             clk;
    logic             BUS_RST;
    addr_req_t        m_aw [N_MST];
    addr_req_t        m_ar [N_MST];
    wr_beat_t         m_w [N_MST];
    rd_beat_t         m_r [N_MST];
    logic [N_MST-1:0] m_aw_valid, m_aw_ready, m_w_valid, m_w_ready;
    logic [N_MST-1:0] m_ar_valid, m_ar_ready, m_r_valid, m_r_ready;
    slv_addr_t        s_aw [N_SLV];
    slv_addr_t        s_ar [N_SLV];
    wr_beat_t         s_w [N_SLV];
    rd_beat_t         s_r [N_SLV];
    logic [N_SLV-1:0] s_aw_valid, s_aw_ready, s_w_valid, s_w_ready;
    logic [N_SLV-1:0] s_ar_valid, s_ar_ready, s_r_valid, s_r_ready;

    int          p_test [$];
    int          p_op [$];     // 0 write, 1 read, 2 write with order check
    int          p_mst [$];
    int          p_len [$];
    logic [31:0] p_addr [$];
    logic [31:0] p_data [$];
    logic [31:0] p_exp [$];
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          limit = 1000;
    int          rd_owner = -1; // master of the read burst in flight

    axi_interconnect #(
        .S0_BASE(32'h0000_0000), .S0_LAST(32'h0FFF_FFFF),
        .S1_BASE(32'h1000_0000), .S1_LAST(32'h1000_000F), .WR_DEPTH(4)
    ) uut (.*);

    axi_slave_model #(.DEPTH(64)) u_s0 (
        .clk(clk), .BUS_RST(BUS_RST),
        .aw(s_aw[0]), .aw_valid(s_aw_valid[0]), .aw_ready(s_aw_ready[0]),
        .w(s_w[0]), .w_valid(s_w_valid[0]), .w_ready(s_w_ready[0]),
        .ar(s_ar[0]), .ar_valid(s_ar_valid[0]), .ar_ready(s_ar_ready[0]),
        .r(s_r[0]), .r_valid(s_r_valid[0]), .r_ready(s_r_ready[0])
    );

    axi_slave_model #(.DEPTH(16)) u_s1 (
        .clk(clk), .BUS_RST(BUS_RST),
        .aw(s_aw[1]), .aw_valid(s_aw_valid[1]), .aw_ready(s_aw_ready[1]),
        .w(s_w[1]), .w_valid(s_w_valid[1]), .w_ready(s_w_ready[1]),
        .ar(s_ar[1]), .ar_valid(s_ar_valid[1]), .ar_ready(s_ar_ready[1]),
        .r(s_r[1]), .r_valid(s_r_valid[1]), .r_ready(s_r_ready[1])
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout: %0d cycles passed with a transfer still pending", cycles);
            $display("Regression failed");
            $finish;
        end
    end

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    // ch 0 write address, 1 write data, 2 read address
    task automatic wait_ready(input int m, input int ch);
        logic got;
        got = 1'b0;
        while (!got) begin
            @(negedge clk);   // nothing moves at mid-cycle
            case (ch)
                0:       got = m_aw_ready[m];
                1:       got = m_w_ready[m];
                default: got = m_ar_ready[m];
            endcase
            @(posedge clk);
        end
        #2;
    endtask

    task automatic do_write(input int m, input logic [31:0] addr, input int len,
                            input logic [31:0] data);
        m_aw[m] = '{addr: addr, len: 8'(len), id: MST_ID_W'(3 - m)};
        m_aw_valid[m] = 1'b1;
        wait_ready(m, 0);
        m_aw_valid[m] = 1'b0;
        for (int b = 0; b <= len; b++) begin
            m_w[m] = '{data: data + 32'(b), strb: 4'hF, last: (b == len)};
            m_w_valid[m] = 1'b1;
            wait_ready(m, 1);
        end
        m_w_valid[m] = 1'b0;
    endtask

    task automatic do_read(input int m, input logic [31:0] addr, input int len,
                           input logic [31:0] exp);
        rd_beat_t beat;
        m_ar[m] = '{addr: addr, len: 8'(len), id: MST_ID_W'(3 - m)};
        m_ar_valid[m] = 1'b1;
        wait_ready(m, 2);
        m_ar_valid[m] = 1'b0;
        for (int b = 0; b <= len; b++) begin
            @(negedge clk);
            while (!m_r_valid[m]) @(negedge clk);
            beat = m_r[m];
            check_word($sformatf("m_r[%0d].data", m), beat.data, exp + 32'(b));
            check_word($sformatf("m_r[%0d].last", m), 32'(beat.last), 32'(b == len));
            check_word($sformatf("m_r[%0d].id", m), 32'(beat.id.raw),
                       32'({2'(m), 2'(3 - m)}));   // master index over own id
            @(posedge clk);
        end
        #2;
    endtask

    task automatic run_master(input int m, input int first, input int stop);
        for (int i = first; i < stop; i++) begin
            if (p_mst[i] == m && p_op[i] == 1) do_read(m, p_addr[i], p_len[i], p_exp[i]);
            else if (p_mst[i] == m) do_write(m, p_addr[i], p_len[i], p_data[i]);
        end
    endtask

    // fixed priority puts the lowest index first
    task automatic check_order(input int first, input int stop, input int log_start);
        int k;
        k = log_start;
        for (int m = 0; m < N_MST; m++) begin
            for (int i = first; i < stop; i++) begin
                if (p_op[i] == 2 && p_mst[i] == m) begin
                    check_word("slave 0 accept order", 32'(u_s0.aw_log[k]), 32'(m));
                    k++;
                end
            end
        end
    endtask

    always @(negedge clk) begin
        if (!BUS_RST) begin
            assert ($onehot0(m_r_valid)) else begin
                $display("read data offered to more than one master at %0t", $time);
                errors++;
            end
            for (int m = 0; m < N_MST; m++) begin
                if (m_r_valid[m] && m_r_ready[m]) begin
                    assert (rd_owner < 0 || rd_owner == m) else begin
                        $display("read burst for master %0d broken by a beat to master %0d at %0t",
                                 rd_owner, m, $time);
                        errors++;
                    end
                    rd_owner = m_r[m].last ? -1 : m;
                end
            end
        end
    end

    initial begin
        int          fd, n, tn, first, stop, err0, log0, n_tests;
        int          f_test, f_op, f_mst, f_len;
        logic [31:0] f_addr, f_data, f_exp;
        string       line;
        void'($urandom(11));
        BUS_RST = 1'b1;
        n_tests = 0;
        for (int i = 0; i < N_MST; i++) begin
            m_aw[i] = '0;
            m_ar[i] = '0;
            m_w[i]  = '0;
        end
        {m_aw_valid, m_w_valid, m_ar_valid} = '0;
        m_r_ready = '1;   // masters always take read data
        fd = $fopen("dv/axi_patterns.txt", "r");
        if (fd == 0) begin
            $display("could not open the pattern file dv/axi_patterns.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%d %d %d %h %d %h %h", f_test, f_op, f_mst, f_addr,
                                f_len, f_data, f_exp);
                    if (n == 7) begin
                        p_test.push_back(f_test);
                        p_op.push_back(f_op);
                        p_mst.push_back(f_mst);
                        p_addr.push_back(f_addr);
                        p_len.push_back(f_len);
                        p_data.push_back(f_data);
                        p_exp.push_back(f_exp);
                    end
                end
            end
            $fclose(fd);
            if (p_test.size() == 0) begin
                $display("no pattern lines found in dv/axi_patterns.txt");
                errors++;
            end
        end
        limit = 200 * p_test.size() + 20;
        repeat (10) @(posedge clk);
        #2 BUS_RST = 1'b0;

        first = 0;
        while (first < p_test.size()) begin
            tn   = p_test[first];
            stop = first;
            while (stop < p_test.size() && p_test[stop] == tn) stop++;
            err0 = errors;
            log0 = u_s0.aw_log.size();
            fork   // all masters start in the same cycle
                run_master(0, first, stop);
                run_master(1, first, stop);
                run_master(2, first, stop);
                run_master(3, first, stop);
            join
            check_order(first, stop, log0);
            $display("test %0d: %0d lines, %0d errors", tn, stop - first, errors - err0);
            n_tests++;
            first = stop;
        end
        $display("%0d tests, %0d checks, %0d errors", n_tests, checks, errors);
        if (errors == 0) $display("Regression passed");
        else $display("Regression failed");
        $finish;
    end

endmodule

// ==== dv/axi_slave_model.sv ====
module axi_slave_model
    import axi_ic_pkg::*;
#(
    parameter int DEPTH = 64
)(
    input  logic      clk,
    input  logic      BUS_RST,
    input  slv_addr_t aw,
    input  logic      aw_valid,
    output logic      aw_ready,
    input  wr_beat_t  w,
    input  logic      w_valid,
    output logic      w_ready,
    input  slv_addr_t ar,
    input  logic      ar_valid,
    output logic      ar_ready,
    output rd_beat_t  r,
    output logic      r_valid,
    input  logic      r_ready
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [31:0] mem [DEPTH];
    slv_addr_t   wq [$];     // write bursts waiting for data
    slv_addr_t   rq [$];     // read bursts waiting to be returned
    int          w_cnt;
    int          r_cnt;
    int          aw_log [$]; // master index of each accepted write address

    // word addressed, an unstripped address falls outside and is lost
    always @(posedge clk) begin
        int idx;
        if (BUS_RST) begin
            aw_ready <= 1'b0;
            w_ready  <= 1'b0;
            ar_ready <= 1'b0;
            r_valid  <= 1'b0;
            r        <= '0;
            wq.delete();
            rq.delete();
            w_cnt = 0;
            r_cnt = 0;
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] = 32'hC0DE_0000 | 32'(i);
            end
        end else begin
            if (aw_valid && aw_ready) begin
                wq.push_back(aw);
                aw_log.push_back(int'(aw.id.f.mst));
            end
            if (w_valid && w_ready && wq.size() > 0) begin
                idx = int'(wq[0].addr) + w_cnt;
                if (idx >= 0 && idx < DEPTH) mem[idx] = w.data;
                w_cnt++;
                if (w.last) begin
                    void'(wq.pop_front());
                    w_cnt = 0;
                end
            end
            if (r_valid && r_ready) begin
                r_cnt++;
                if (r.last) begin
                    void'(rq.pop_front());
                    r_cnt = 0;
                end
            end
            if (ar_valid && ar_ready) rq.push_back(ar);
            // a beat on offer stays until taken
            if (!r_valid || r_ready) begin
                if (rq.size() > 0 && $urandom_range(3) != 0) begin
                    idx = int'(rq[0].addr) + r_cnt;
                    r_valid <= 1'b1;
                    r.data  <= (idx >= 0 && idx < DEPTH) ? mem[idx] : 32'hBAD0_0000;
                    r.last  <= (r_cnt == int'(rq[0].len));
                    r.id    <= rq[0].id;
                end else begin
                    r_valid <= 1'b0;
                end
            end
            aw_ready <= ($urandom_range(3) != 0);   // stall about one cycle in four
            w_ready  <= ($urandom_range(3) != 0);
            ar_ready <= ($urandom_range(3) != 0);
        end
    end

endmodule

// ==== verilog/axi_interconnect.sv ====
module axi_interconnect
    import axi_ic_pkg::*;
#(
    parameter logic [31:0] S0_BASE  = 32'h0000_0000,
    parameter logic [31:0] S0_LAST  = 32'h0FFF_FFFF,
    parameter logic [31:0] S1_BASE  = 32'h1000_0000,
    parameter logic [31:0] S1_LAST  = 32'h1000_000F,
    parameter int          WR_DEPTH = 4
)(
    input  logic             clk,
    input  logic             BUS_RST,

    // master side
    input  addr_req_t        m_aw [N_MST],
    input  logic [N_MST-1:0] m_aw_valid,
    output logic [N_MST-1:0] m_aw_ready,
    input  wr_beat_t         m_w [N_MST],
    input  logic [N_MST-1:0] m_w_valid,
    output logic [N_MST-1:0] m_w_ready,
    input  addr_req_t        m_ar [N_MST],
    input  logic [N_MST-1:0] m_ar_valid,
    output logic [N_MST-1:0] m_ar_ready,
    output rd_beat_t         m_r [N_MST],
    output logic [N_MST-1:0] m_r_valid,
    input  logic [N_MST-1:0] m_r_ready,

    // slave side
    output slv_addr_t        s_aw [N_SLV],
    output logic [N_SLV-1:0] s_aw_valid,
    input  logic [N_SLV-1:0] s_aw_ready,
    output wr_beat_t         s_w [N_SLV],
    output logic [N_SLV-1:0] s_w_valid,
    input  logic [N_SLV-1:0] s_w_ready,
    output slv_addr_t        s_ar [N_SLV],
    output logic [N_SLV-1:0] s_ar_valid,
    input  logic [N_SLV-1:0] s_ar_ready,
    input  rd_beat_t         s_r [N_SLV],
    input  logic [N_SLV-1:0] s_r_valid,
    output logic [N_SLV-1:0] s_r_ready
);

    addr_req_t            aw_bus;
    logic                 aw_bus_valid;
    logic [MST_IDX_W-1:0] aw_bus_mst;
    logic                 aw_bus_ready;
    addr_req_t            ar_bus;
    logic                 ar_bus_valid;
    logic [MST_IDX_W-1:0] ar_bus_mst;
    logic                 ar_bus_ready;
    logic                 wq_push;
    logic                 wq_slv;
    logic                 wq_full;

    // write address path
    addr_arbiter u_aw_arb (
        .clk(clk), .BUS_RST(BUS_RST),
        .req(m_aw), .req_valid(m_aw_valid), .req_ready(m_aw_ready),
        .bus_req(aw_bus), .bus_valid(aw_bus_valid), .bus_mst(aw_bus_mst),
        .bus_ready(aw_bus_ready)
    );

    addr_decoder #(
        .S0_BASE(S0_BASE), .S0_LAST(S0_LAST), .S1_BASE(S1_BASE), .S1_LAST(S1_LAST)
    ) u_aw_dec (
        .bus_req(aw_bus), .bus_valid(aw_bus_valid), .bus_mst(aw_bus_mst),
        .bus_ready(aw_bus_ready), .accept_ok(!wq_full),
        .slv_req(s_aw), .slv_valid(s_aw_valid), .slv_ready(s_aw_ready),
        .push(wq_push), .push_slv(wq_slv)
    );

    // read address path, no order tracking needed
    addr_arbiter u_ar_arb (
        .clk(clk), .BUS_RST(BUS_RST),
        .req(m_ar), .req_valid(m_ar_valid), .req_ready(m_ar_ready),
        .bus_req(ar_bus), .bus_valid(ar_bus_valid), .bus_mst(ar_bus_mst),
        .bus_ready(ar_bus_ready)
    );

    addr_decoder #(
        .S0_BASE(S0_BASE), .S0_LAST(S0_LAST), .S1_BASE(S1_BASE), .S1_LAST(S1_LAST)
    ) u_ar_dec (
        .bus_req(ar_bus), .bus_valid(ar_bus_valid), .bus_mst(ar_bus_mst),
        .bus_ready(ar_bus_ready), .accept_ok(1'b1),
        .slv_req(s_ar), .slv_valid(s_ar_valid), .slv_ready(s_ar_ready),
        .push(), .push_slv()
    );

    wr_data_router #(.WR_DEPTH(WR_DEPTH)) u_wr (
        .clk(clk), .BUS_RST(BUS_RST),
        .push(wq_push), .push_mst(aw_bus_mst), .push_slv(wq_slv), .full(wq_full),
        .mst_beat(m_w), .mst_valid(m_w_valid), .mst_ready(m_w_ready),
        .slv_beat(s_w), .slv_valid(s_w_valid), .slv_ready(s_w_ready)
    );

    rd_data_router u_rd (
        .clk(clk), .BUS_RST(BUS_RST),
        .slv_beat(s_r), .slv_valid(s_r_valid), .slv_ready(s_r_ready),
        .mst_beat(m_r), .mst_valid(m_r_valid), .mst_ready(m_r_ready)
    );

endmodule

// ==== verilog/rd_data_router.sv ====
module rd_data_router
    import axi_ic_pkg::*;
(
    input  logic             clk,
    input  logic             BUS_RST,

    input  rd_beat_t         slv_beat [N_SLV],
    input  logic [N_SLV-1:0] slv_valid,
    output logic [N_SLV-1:0] slv_ready,

    output rd_beat_t         mst_beat [N_MST],
    output logic [N_MST-1:0] mst_valid,
    input  logic [N_MST-1:0] mst_ready
);

    logic                 locked;
    logic                 lock_slv;
    logic                 sel;
    rd_beat_t             cur;
    logic                 cur_valid;
    logic [MST_IDX_W-1:0] dest;
    logic                 hs;
    logic                 burst_end;

    // slave 0 first when free, otherwise stay on the locked stream
    assign sel       = locked ? lock_slv : !slv_valid[0];
    assign cur       = slv_beat[sel];
    assign cur_valid = slv_valid[sel];
    assign dest      = cur.id.f.mst;     // upper id bits name the master

    assign hs        = cur_valid && mst_ready[dest];
    assign burst_end = hs && cur.last;

    always_comb begin
        mst_valid = '0;
        slv_ready = '0;
        for (int m = 0; m < N_MST; m++) begin
            mst_beat[m] = cur;
        end
        mst_valid[dest] = cur_valid;
        slv_ready[sel]  = mst_ready[dest];
    end

    always_ff @(posedge clk) begin
        if (BUS_RST) begin
            locked   <= 1'b0;
            lock_slv <= 1'b0;
        end else if (!locked) begin
            // single-beat bursts never lock
            if (cur_valid && !burst_end) begin
                locked   <= 1'b1;
                lock_slv <= sel;
            end
        end else if (burst_end) begin
            locked <= 1'b0;
        end
    end

    // a locked stream carries one burst, so one id
    a_lock_id: assert property (
        @(posedge clk) disable iff (BUS_RST)
        locked && cur_valid && !burst_end
            |=> (!cur_valid || cur.id.raw == $past(cur.id.raw))
    );

endmodule

// ==== verilog/wr_data_router.sv ====
module wr_data_router
    import axi_ic_pkg::*;
#(
    parameter int WR_DEPTH = 4
)(
    input  logic                 clk,
    input  logic                 BUS_RST,

    input  logic                 push,
    input  logic [MST_IDX_W-1:0] push_mst,
    input  logic                 push_slv,
    output logic                 full,

    input  wr_beat_t             mst_beat [N_MST],
    input  logic [N_MST-1:0]     mst_valid,
    output logic [N_MST-1:0]     mst_ready,

    output wr_beat_t             slv_beat [N_SLV],
    output logic [N_SLV-1:0]     slv_valid,
    input  logic [N_SLV-1:0]     slv_ready
);

    localparam int PTR_W = $clog2(WR_DEPTH);

    // order queue, one entry per accepted write address
    logic [MST_IDX_W-1:0] q_mst [WR_DEPTH];
    logic                 q_slv [WR_DEPTH];
    logic [PTR_W-1:0]     wr_ptr;
    logic [PTR_W-1:0]     rd_ptr;
    logic [PTR_W:0]       count;

    logic [MST_IDX_W-1:0] head_mst;
    logic                 head_slv;
    logic                 head_ok;
    logic                 pop;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(WR_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign head_mst = q_mst[rd_ptr];
    assign head_slv = q_slv[rd_ptr];
    assign head_ok  = (count != '0);
    assign full     = (count == (PTR_W+1)'(WR_DEPTH));

    // burst done once its last beat is taken
    assign pop = head_ok && mst_valid[head_mst] && slv_ready[head_slv]
                 && mst_beat[head_mst].last;

    always_comb begin
        mst_ready = '0;
        slv_valid = '0;
        for (int s = 0; s < N_SLV; s++) begin
            slv_beat[s] = mst_beat[head_mst];
        end
        if (head_ok) begin
            slv_valid[head_slv] = mst_valid[head_mst];
            mst_ready[head_mst] = slv_ready[head_slv];
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            q_mst[wr_ptr] <= push_mst;
            q_slv[wr_ptr] <= push_slv;
        end
    end

    always_ff @(posedge clk) begin
        if (BUS_RST) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= ptr_inc(wr_ptr);
            if (pop)  rd_ptr <= ptr_inc(rd_ptr);
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;                         // both or neither
            endcase
        end
    end

    // the decoder must hold off acceptance while the queue is full
    a_no_push_full: assert property (
        @(posedge clk) disable iff (BUS_RST) push |-> !full
    );

endmodule

// ==== verilog/addr_decoder.sv ====
module addr_decoder
    import axi_ic_pkg::*;
#(
    parameter logic [31:0] S0_BASE = 32'h0000_0000,
    parameter logic [31:0] S0_LAST = 32'h0FFF_FFFF,
    parameter logic [31:0] S1_BASE = 32'h1000_0000,
    parameter logic [31:0] S1_LAST = 32'h1000_000F
)(
    input  addr_req_t            bus_req,
    input  logic                 bus_valid,
    input  logic [MST_IDX_W-1:0] bus_mst,
    output logic                 bus_ready,
    input  logic                 accept_ok,    // low stalls acceptance

    output slv_addr_t            slv_req [N_SLV],
    output logic [N_SLV-1:0]     slv_valid,
    input  logic [N_SLV-1:0]     slv_ready,

    output logic                 push,
    output logic                 push_slv
);

    logic    in_s0;
    logic    in_s1;
    logic    slv_sel;    // 0 memory, 1 registers
    slv_id_u sid;

    assign in_s0 = (bus_req.addr >= S0_BASE) && (bus_req.addr <= S0_LAST);
    assign in_s1 = (bus_req.addr >= S1_BASE) && (bus_req.addr <= S1_LAST);

    // register window wins on overlap, unmapped goes to slave 1 as well
    assign slv_sel = !in_s0 || in_s1;

    always_comb begin
        sid.f.mst = bus_mst;
        sid.f.tag = bus_req.id;

        slv_req[0] = '{addr: {{(32-S0_ADDR_W){1'b0}}, bus_req.addr[S0_ADDR_W-1:0]},
                       len: bus_req.len, id: sid};
        slv_req[1] = '{addr: {{(32-S1_ADDR_W){1'b0}}, bus_req.addr[S1_ADDR_W-1:0]},
                       len: bus_req.len, id: sid};

        slv_valid          = '0;
        slv_valid[slv_sel] = bus_valid && accept_ok;
    end

    assign bus_ready = slv_ready[slv_sel] && accept_ok;

    // accepted address, tells the write router who talks to whom
    assign push     = bus_valid && bus_ready;
    assign push_slv = slv_sel;

endmodule

// ==== verilog/addr_arbiter.sv ====
module addr_arbiter
    import axi_ic_pkg::*;
(
    input  logic                 clk,
    input  logic                 BUS_RST,

    input  addr_req_t            req [N_MST],
    input  logic [N_MST-1:0]     req_valid,
    output logic [N_MST-1:0]     req_ready,

    output addr_req_t            bus_req,
    output logic                 bus_valid,
    output logic [MST_IDX_W-1:0] bus_mst,
    input  logic                 bus_ready
);

    logic [MST_IDX_W-1:0] grant;
    logic [MST_IDX_W-1:0] grant_nxt;
    logic                 bus_free;

    // free when nothing is offered or the current request just went through
    assign bus_free = !bus_valid || bus_ready;

    always_comb begin
        grant_nxt = grant;
        if (bus_free) begin
            grant_nxt = '0;    // idle default is master 0
            // walk down so the lowest index wins
            for (int i = N_MST - 1; i >= 0; i--) begin
                if (req_valid[i]) begin
                    grant_nxt = MST_IDX_W'(i);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (BUS_RST) begin
            grant <= '0;
        end else begin
            grant <= grant_nxt;
        end
    end

    // payload straight from the granted master
    assign bus_req   = req[grant];
    assign bus_valid = req_valid[grant];
    assign bus_mst   = grant;

    always_comb begin
        req_ready        = '0;
        req_ready[grant] = bus_ready;   // losers see ready low
    end

    // a pending request keeps its grant and payload until the slave takes it
    a_grant_hold: assert property (
        @(posedge clk) disable iff (BUS_RST)
        bus_valid && !bus_ready |=> bus_valid && bus_mst == $past(bus_mst)
            && bus_req == $past(bus_req)
    );

endmodule

// ==== verilog/axi_ic_pkg.sv ====
package axi_ic_pkg;

    localparam int MST_ID_W  = 2;    // id as issued by a master
    localparam int SLV_ID_W  = 4;    // id as seen by a slave
    localparam int N_MST     = 4;
    localparam int N_SLV     = 2;
    localparam int MST_IDX_W = $clog2(N_MST);

    localparam int S0_ADDR_W = 28;   // memory window
    localparam int S1_ADDR_W = 4;    // register window

    // upper bits name the master, lower bits are its own id
    typedef struct packed {
        logic [MST_IDX_W-1:0] mst;
        logic [MST_ID_W-1:0]  tag;
    } slv_id_s;

    typedef union packed {
        logic [SLV_ID_W-1:0] raw;
        slv_id_s             f;
    } slv_id_u;

    typedef struct packed {
        logic [31:0]         addr;
        logic [7:0]          len;    // beats - 1
        logic [MST_ID_W-1:0] id;
    } addr_req_t;

    typedef struct packed {
        logic [31:0] addr;           // stripped, upper bits zero
        logic [7:0]  len;
        slv_id_u     id;
    } slv_addr_t;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
        logic        last;
    } wr_beat_t;

    typedef struct packed {
        logic [31:0] data;
        logic        last;
        slv_id_u     id;
    } rd_beat_t;

endpackage
